// File: include/screen_macros.svh
`ifndef SCREEN_MACROS_SVH
`define SCREEN_MACROS_SVH

// screen and sprite geometry
`define SCREEN_W      160
`define SCREEN_H      120
`define PLAYER_SIZE   9
`define BARREL_SIZE   5

// coordinate and colour widths
`define XW            8
`define YW            7
`define COLOR_W       3

// solid fill colours
`define COL_START     1
`define COL_GAME      2
`define COL_LOSE      4
`define COL_WIN       6

// player must reach this column at or above this row
`define WIN_X         115
`define WIN_Y_MAX     5

`define PIX_CREDITS   8
`define CREDIT_W      4 // holds 0..PIX_CREDITS

`endif

// File: design/screen_pkg.sv
`default_nettype none

`include "screen_macros.svh"

package screen_pkg;

	typedef enum logic [1:0] {
		fillJob   = 2'd0,
		playerJob = 2'd1,
		barrelJob = 2'd2
	} jobKind_e;

	// screen fill, colour in the top bits
	typedef struct packed {
		logic [`COLOR_W-1:0]             color;
		logic [`XW+`YW-`COLOR_W-1:0]     pad;
	} fillArgs_t;

	// sprite origin, top left corner
	typedef struct packed {
		logic [`XW-1:0] x;
		logic [`YW-1:0] y;
	} spriteArgs_t;

	typedef union packed {
		fillArgs_t   fill;
		spriteArgs_t sprite;
	} drawArgs_u;

	typedef struct packed {
		jobKind_e  kind;
		drawArgs_u args;
	} drawJob_t;

endpackage

`default_nettype wire

// File: design/gameSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "screen_macros.svh"

module gameSequencer (
	input wire clk,
	input wire resetn,
	input wire startGame,
	input wire advance,
	input wire moveStrobe,
	input wire gameOver,
	input wire [`XW-1:0] playerX,
	input wire [`YW-1:0] playerY,
	input wire [`XW-1:0] barrelX,
	input wire [`YW-1:0] barrelY,
	input wire jobReady,
	input wire jobDone,
	output logic jobValid,
	output screen_pkg::drawJob_t job,
	output logic frameDone
);
	import screen_pkg::*;

	typedef enum logic [3:0] {
		sIdle, sStart, sWaitAdv, sAdvance, sWaitMove, sMove, sLose, sWin, sDone
	} seqState_e;

	seqState_e state;
	logic [1:0] jobIdx;
	logic [1:0] lastIdx;
	logic [`XW-1:0] plX;
	logic [`XW-1:0] brX;
	logic [`YW-1:0] plY;
	logic [`YW-1:0] brY;
	logic capture;
	logic won;

	assign capture = (state == sWaitAdv && advance) || (state == sWaitMove && moveStrobe);
	assign won = (plX == `XW'(`WIN_X)) && (plY <= `YW'(`WIN_Y_MAX));

	// jobs per frame: fill, then player, then barrel
	always_comb begin
		case (state)
			sAdvance: lastIdx = 2'd1;
			sMove:    lastIdx = 2'd2;
			default:  lastIdx = 2'd0;
		endcase
	end

	always_comb begin
		job.kind = fillJob;
		job.args.fill.color = `COLOR_W'(`COL_GAME);
		job.args.fill.pad = '0;
		case (state)
			sStart: job.args.fill.color = `COLOR_W'(`COL_START);
			sLose:  job.args.fill.color = `COLOR_W'(`COL_LOSE);
			sWin:   job.args.fill.color = `COLOR_W'(`COL_WIN);
			default: begin
				if (jobIdx == 2'd1) begin
					job.kind = playerJob;
					job.args.sprite.x = plX;
					job.args.sprite.y = plY;
				end else if (jobIdx == 2'd2) begin
					job.kind = barrelJob;
					job.args.sprite.x = brX;
					job.args.sprite.y = brY;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			plX <= playerX;
			plY <= playerY;
			brX <= barrelX;
			brY <= barrelY;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= sIdle;
			jobIdx <= 2'd0;
			jobValid <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			frameDone <= 1'b0;
			if (jobValid && jobReady)
				jobValid <= 1'b0; // accepted, now wait for jobDone
			case (state)
				sIdle: if (startGame) begin
					state <= sStart;
					jobIdx <= 2'd0;
					jobValid <= 1'b1;
				end
				sWaitAdv: if (advance) begin
					state <= sAdvance;
					jobIdx <= 2'd0;
					jobValid <= 1'b1;
				end
				sWaitMove: if (moveStrobe) begin
					state <= sMove;
					jobIdx <= 2'd0;
					jobValid <= 1'b1;
				end
				sDone: ; // stays here until reset
				default: if (jobDone) begin
					if (jobIdx == lastIdx) begin
						frameDone <= 1'b1;
						jobIdx <= 2'd0;
						case (state)
							sStart:   state <= sWaitAdv;
							sAdvance: state <= sWaitMove;
							sMove: begin
								// lose wins over the position test
								if (gameOver) begin
									state <= sLose;
									jobValid <= 1'b1;
								end else if (won) begin
									state <= sWin;
									jobValid <= 1'b1;
								end else begin
									state <= sWaitMove;
								end
							end
							default:  state <= sDone;
						endcase
					end else begin
						jobIdx <= jobIdx + 2'd1;
						jobValid <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/rasterWalker.sv
`timescale 1ns/1ps
`default_nettype none

`include "screen_macros.svh"

module rasterWalker (
	input wire clk,
	input wire resetn,
	input wire jobValid,
	input wire screen_pkg::drawJob_t job,
	input wire creditReturn,
	output logic jobReady,
	output logic jobDone,
	output logic stepValid,
	output logic [`XW-1:0] stepX,
	output logic [`YW-1:0] stepY,
	output screen_pkg::jobKind_e stepKind,
	output screen_pkg::drawArgs_u stepArgs
);
	import screen_pkg::*;

	logic busy;
	jobKind_e kindQ;
	drawArgs_u argsQ;
	logic [`XW-1:0] offX;
	logic [`XW-1:0] lastX;
	logic [`YW-1:0] offY;
	logic [`YW-1:0] lastY;
	logic [`CREDIT_W-1:0] credits;
	logic fire;
	logic rowEnd;

	// rectangle size from the job kind
	always_comb begin
		case (kindQ)
			playerJob: begin
				lastX = `XW'(`PLAYER_SIZE - 1);
				lastY = `YW'(`PLAYER_SIZE - 1);
			end
			barrelJob: begin
				lastX = `XW'(`BARREL_SIZE - 1);
				lastY = `YW'(`BARREL_SIZE - 1);
			end
			default: begin
				lastX = `XW'(`SCREEN_W - 1);
				lastY = `YW'(`SCREEN_H - 1);
			end
		endcase
	end

	assign jobReady = !busy;
	assign fire = busy && (credits != '0); // no credit, no step
	assign rowEnd = (offX == lastX);
	assign jobDone = fire && rowEnd && (offY == lastY);

	assign stepValid = fire;
	assign stepX = offX;
	assign stepY = offY;
	assign stepKind = kindQ;
	assign stepArgs = argsQ;

	always_ff @(posedge clk) begin
		if (jobValid && jobReady) begin
			kindQ <= job.kind;
			argsQ <= job.args;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			offX <= '0;
			offY <= '0;
		end else if (jobValid && jobReady) begin
			busy <= 1'b1;
			offX <= '0;
			offY <= '0;
		end else if (fire) begin
			if (rowEnd) begin
				offX <= '0;
				if (offY == lastY)
					busy <= 1'b0;
				else
					offY <= offY + 1'b1;
			end else begin
				offX <= offX + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			credits <= `CREDIT_W'(`PIX_CREDITS);
		else begin
			case ({creditReturn, fire})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: ; // both or neither cancel out
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/pixelComposer.sv
`timescale 1ns/1ps
`default_nettype none

`include "screen_macros.svh"

module pixelComposer (
	input wire clk,
	input wire resetn,
	input wire stepValid,
	input wire [`XW-1:0] stepX,
	input wire [`YW-1:0] stepY,
	input wire screen_pkg::jobKind_e stepKind,
	input wire screen_pkg::drawArgs_u stepArgs,
	output logic pixValid,
	output logic [`XW-1:0] pixX,
	output logic [`YW-1:0] pixY,
	output logic [`COLOR_W-1:0] pixColor
);
	import screen_pkg::*;

	localparam int RowW = `PLAYER_SIZE * `COLOR_W;
	localparam int RomDepth = `PLAYER_SIZE + `BARREL_SIZE;

	// one word per sprite row, column c at bits [c*COLOR_W +: COLOR_W]
	// player rows 0..8, barrel rows 9..13
	logic [RowW-1:0] rom [0:RomDepth-1];

	logic [3:0] romRow;
	logic [RowW-1:0] rowBits;
	logic [`COLOR_W-1:0] spriteColor;
	logic [`XW-1:0] nextX;
	logic [`YW-1:0] nextY;
	logic [`COLOR_W-1:0] nextColor;

	initial begin
		$readmemh("design/spriteRom.mem", rom);
	end

	assign romRow = (stepKind == barrelJob) ? 4'(`PLAYER_SIZE) + stepY[3:0] : stepY[3:0];
	assign rowBits = rom[romRow] >> (`COLOR_W * stepX[3:0]);
	assign spriteColor = rowBits[`COLOR_W-1:0];

	always_comb begin
		if (stepKind == fillJob) begin
			nextX = stepX;
			nextY = stepY;
			nextColor = stepArgs.fill.color;
		end else begin
			nextX = stepArgs.sprite.x + stepX; // wraps at the coordinate width
			nextY = stepArgs.sprite.y + stepY;
			nextColor = spriteColor;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			pixValid <= 1'b0;
		else
			pixValid <= stepValid;
	end

	always_ff @(posedge clk) begin
		pixX <= nextX;
		pixY <= nextY;
		pixColor <= nextColor;
	end

endmodule

`default_nettype wire

// File: design/screenDrawTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "screen_macros.svh"

module screenDrawTop (
	input wire clk,
	input wire resetn,
	input wire startGame,
	input wire advance,
	input wire moveStrobe,
	input wire gameOver,
	input wire [`XW-1:0] playerX,
	input wire [`YW-1:0] playerY,
	input wire [`XW-1:0] barrelX,
	input wire [`YW-1:0] barrelY,
	input wire creditReturn,
	output logic pixValid,
	output logic [`XW-1:0] pixX,
	output logic [`YW-1:0] pixY,
	output logic [`COLOR_W-1:0] pixColor,
	output logic frameDone
);
	import screen_pkg::*;

	logic jobValid;
	logic jobReady;
	logic jobDone;
	drawJob_t job;
	logic stepValid;
	logic [`XW-1:0] stepX;
	logic [`YW-1:0] stepY;
	jobKind_e stepKind;
	drawArgs_u stepArgs;

	gameSequencer decode (
		.clk(clk), .resetn(resetn),
		.startGame(startGame), .advance(advance), .moveStrobe(moveStrobe),
		.gameOver(gameOver),
		.playerX(playerX), .playerY(playerY), .barrelX(barrelX), .barrelY(barrelY),
		.jobReady(jobReady), .jobDone(jobDone),
		.jobValid(jobValid), .job(job), .frameDone(frameDone)
	);

	rasterWalker execute (
		.clk(clk), .resetn(resetn),
		.jobValid(jobValid), .job(job), .creditReturn(creditReturn),
		.jobReady(jobReady), .jobDone(jobDone),
		.stepValid(stepValid), .stepX(stepX), .stepY(stepY),
		.stepKind(stepKind), .stepArgs(stepArgs)
	);

	pixelComposer result (
		.clk(clk), .resetn(resetn),
		.stepValid(stepValid), .stepX(stepX), .stepY(stepY),
		.stepKind(stepKind), .stepArgs(stepArgs),
		.pixValid(pixValid), .pixX(pixX), .pixY(pixY), .pixColor(pixColor)
	);

endmodule

`default_nettype wire

// File: verification/screenDraw_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "screen_macros.svh"

module screenDraw_assert (
	input wire clk,
	input wire resetn,
	input wire jobValid,
	input wire screen_pkg::drawJob_t job,
	input wire jobReady,
	input wire creditReturn,
	input wire stepValid,
	input wire [`CREDIT_W-1:0] credits
);
	import screen_pkg::*;

	// credits seen on the link, returns in and steps out
	int linkCredits;

	always_ff @(posedge clk) begin
		if (!resetn)
			linkCredits <= `PIX_CREDITS;
		else
			linkCredits <= linkCredits + int'(creditReturn) - int'(stepValid);
	end

	stepNeedsCredit: assert property (@(posedge clk) disable iff (!resetn)
		stepValid |-> (linkCredits > 0))
		else $error("step issued with no credit left");

	creditCeiling: assert property (@(posedge clk) disable iff (!resetn)
		credits <= `CREDIT_W'(`PIX_CREDITS))
		else $error("credit counter above its limit");

	// job must hold while waiting for the walker
	jobHeld: assert property (@(posedge clk) disable iff (!resetn)
		(jobValid && !jobReady) |=> $stable(job))
		else $error("job changed before it was accepted");

endmodule

bind rasterWalker screenDraw_assert walkerChecks (
	.clk(clk), .resetn(resetn),
	.jobValid(jobValid), .job(job), .jobReady(jobReady),
	.creditReturn(creditReturn),
	.stepValid(stepValid), .credits(credits)
);

`default_nettype wire

// File: verification/screenDraw_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "screen_macros.svh"

module screenDraw_tb;

	logic clk;
	logic resetn;
	logic startGame;
	logic advance;
	logic moveStrobe;
	logic gameOver;
	logic [`XW-1:0] playerX;
	logic [`YW-1:0] playerY;
	logic [`XW-1:0] barrelX;
	logic [`YW-1:0] barrelY;
	logic creditReturn;
	logic pixValid;
	logic [`XW-1:0] pixX;
	logic [`YW-1:0] pixY;
	logic [`COLOR_W-1:0] pixColor;
	logic frameDone;

	int evCode[0:63];
	int evPx[0:63];
	int evPy[0:63];
	int evBx[0:63];
	int evBy[0:63];
	int evGo[0:63];
	int expCount[0:63];
	int expColor[0:63];
	int expCoord[0:63];
	int numEvents = 0;

	int errors = 0;
	int framesChecked = 0;
	int cycle = 0;
	int cycleLimit = 0;
	logic quiet = 1'b1; // no pixel may show up while set

	int accCount = 0;
	int accColor = 0;
	int accCoord = 0;
	int frmCount[$];
	int frmColor[$];
	int frmCoord[$];
	int dueQ[$]; // cycle at which each pending credit goes back
	int readyCredits = 0;
	int outstanding = 0;

	screenDrawTop uut (
		.clk(clk), .resetn(resetn),
		.startGame(startGame), .advance(advance), .moveStrobe(moveStrobe),
		.gameOver(gameOver),
		.playerX(playerX), .playerY(playerY), .barrelX(barrelX), .barrelY(barrelY),
		.creditReturn(creditReturn),
		.pixValid(pixValid), .pixX(pixX), .pixY(pixY), .pixColor(pixColor),
		.frameDone(frameDone)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual) begin
			errors++;
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	// frame totals, sampled half a clock after the edge
	always @(negedge clk) begin
		if (quiet) begin
			check("pixValid", 0, int'(pixValid));
			check("frameDone", 0, int'(frameDone));
		end
		if (!resetn) begin
			accCount = 0;
			accColor = 0;
			accCoord = 0;
		end else begin
			if (pixValid) begin
				accCount++;
				accColor += int'(pixColor);
				accCoord += int'(pixX) + int'(pixY);
				outstanding++;
				dueQ.push_back(cycle + int'($urandom % 32'd4));
				if (outstanding > `PIX_CREDITS) begin
					errors++;
					$display("at %0t %0d pixels are outstanding, more than the %0d credits",
						$time, outstanding, `PIX_CREDITS);
				end
			end
			if (frameDone) begin
				frmCount.push_back(accCount);
				frmColor.push_back(accColor);
				frmCoord.push_back(accCoord);
				accCount = 0;
				accColor = 0;
				accCoord = 0;
			end
		end
	end

	// credit return, one per cycle at most
	always @(posedge clk) begin : creditDriver
		logic inReset;
		inReset = !resetn;
		cycle++;
		#2;
		if (inReset) begin
			dueQ.delete();
			readyCredits = 0;
			outstanding = 0;
			creditReturn = 1'b0;
		end else begin
			for (int i = dueQ.size() - 1; i >= 0; i--) begin
				if (dueQ[i] <= cycle) begin
					readyCredits++;
					dueQ.delete(i);
				end
			end
			if (readyCredits > 0) begin
				creditReturn = 1'b1;
				readyCredits--;
				outstanding--;
			end else begin
				creditReturn = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (cycleLimit > 0 && cycle >= cycleLimit) begin
			$display("run timed out after %0d cycles waiting for the DUT", cycle);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic loadEvents();
		int fd;
		int n;
		string line;
		int code, px, py, bx, by, go, cnt, col, crd;
		fd = $fopen("verification/screen_input.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %d %d %d %d %d %d %d %d",
							code, px, py, bx, by, go, cnt, col, crd) == 9) begin
						evCode[numEvents] = code;
						evPx[numEvents] = px;
						evPy[numEvents] = py;
						evBx[numEvents] = bx;
						evBy[numEvents] = by;
						evGo[numEvents] = go;
						expCount[numEvents] = cnt;
						expColor[numEvents] = col;
						expCoord[numEvents] = crd;
						numEvents++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic applyReset();
		@(posedge clk);
		#2;
		resetn = 1'b0;
		quiet = 1'b1;
		startGame = 1'b0;
		advance = 1'b0;
		moveStrobe = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		resetn = 1'b1;
		repeat (5) @(posedge clk);
	endtask

	// one-cycle strobe for start, advance or move
	task automatic driveEvent(input int idx);
		@(posedge clk);
		#2;
		playerX = `XW'(evPx[idx]);
		playerY = `YW'(evPy[idx]);
		barrelX = `XW'(evBx[idx]);
		barrelY = `YW'(evBy[idx]);
		gameOver = (evGo[idx] != 0);
		case (evCode[idx])
			1: begin
				quiet = 1'b0;
				startGame = 1'b1;
			end
			2: advance = 1'b1;
			default: moveStrobe = 1'b1;
		endcase
		@(posedge clk);
		#2;
		startGame = 1'b0;
		advance = 1'b0;
		moveStrobe = 1'b0;
	endtask

	task automatic checkFrame(input int idx);
		while (frmCount.size() == 0)
			@(posedge clk);
		check("frame pixel count", expCount[idx], frmCount.pop_front());
		check("frame pixColor sum", expColor[idx], frmColor.pop_front());
		check("frame pixX+pixY sum", expCoord[idx], frmCoord.pop_front());
		framesChecked++;
	endtask

	task automatic checkIdle();
		repeat (200) @(posedge clk);
		check("frames after end screen", 0, frmCount.size());
		check("pixels after end screen", 0, accCount);
	endtask

	initial begin
		int total;
		void'($urandom(32'h5604));
		resetn = 1'b0;
		startGame = 1'b0;
		advance = 1'b0;
		moveStrobe = 1'b0;
		gameOver = 1'b0;
		playerX = '0;
		playerY = '0;
		barrelX = '0;
		barrelY = '0;
		creditReturn = 1'b0;
		total = 0;
		loadEvents();
		if (numEvents == 0) begin
			$display("could not read any events from verification/screen_input.txt");
			$display("CHECKS FAILED");
		end else begin
			for (int i = 0; i < numEvents; i++)
				total += expCount[i];
			cycleLimit = 4 * total + 1000;
			applyReset();
			for (int i = 0; i < numEvents; i++) begin
				case (evCode[i])
					0: applyReset();
					1, 2, 3: begin
						driveEvent(i);
						checkFrame(i);
					end
					4: checkFrame(i);
					default: checkIdle();
				endcase
			end
			$display("errors: %0d, frames checked: %0d", errors, framesChecked);
			if (errors == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/spriteRom.mem
36DB6DB
36DB6DB
5B6DB6D
5B6DB6D
7FFFFFF
5B6DB6D
5B6DB6D
36DB6DB
36DB6DB
4924
7FFF
4924
7FFF
4924

// File: compile.f
+incdir+include
design/screen_pkg.sv
design/gameSequencer.sv
design/rasterWalker.sv
design/pixelComposer.sv
design/screenDrawTop.sv
verification/screenDraw_assert.sv
verification/screenDraw_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = screenDraw_tb
FILELIST  = compile.f
LOG       = sim.log
PASSMSG   = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/screen_input.txt
# code px py bx by gameOver | expected pixel count, colour sum, pixX+pixY sum
# code 0 reset, 1 start, 2 advance, 3 move, 4 end frame, 5 idle with no pixels
1 0 0 0 0 0 19200 19200 2668800
2 10 20 50 60 0 19281 38751 2671878
3 20 30 40 50 0 19306 38881 2675848
3 60 70 100 10 0 19306 38881 2682828
3 115 40 30 100 0 19306 38881 2685353
3 5 5 8 9 1 19306 38881 2670783
# lose screen follows the last move on its own
4 0 0 0 0 1 19200 76800 2668800
5 0 0 0 0 1 0 0 0
0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 19200 19200 2668800
2 0 0 0 0 0 19281 38751 2669448
3 115 3 12 7 0 19306 38881 2679581
# win screen
4 0 0 0 0 0 19200 115200 2668800
5 0 0 0 0 0 0 0 0
